//--- common/dps_defs.svh
//********************************************************************
// Constants of the debug port, pulled in by the TAP, the SPI device
// and the top level through an include
//********************************************************************
`ifndef DPS_DEFS_SVH
`define DPS_DEFS_SVH

// Device identification, LSB must be 1 per 1149.1
`define DPS_IDCODE 32'h1A5B_03E1

// Instruction register
`define DPS_IR_W 5
`define DPS_IR_IDCODE 5'h01
`define DPS_IR_BYPASS 5'h1F  // All ones

// SPI device word
`define DPS_SPI_W 8

`endif

//--- common/dps_pkg.sv
//********************************************************************
// Shared types for the debug-port block: pad and strap bundles, the
// JTAG and SPI views of the shared pads, and the TAP state encoding
//********************************************************************
package dps_pkg;

  // Shared DPS pads as they arrive from the pad ring
  typedef struct packed {
    logic sck_tck;
    logic sdi_tdi;
    logic csb_tms;
    logic trst_n;
  } dps_pad_t;

  typedef struct packed {
    logic jtag_spi_n;  // 1 selects JTAG
    logic bootstrap;
    logic srst_n;
  } dps_strap_t;

  // Pads as seen by the TAP
  typedef struct packed {
    logic tck;
    logic tms;
    logic tdi;
    logic trst_n;
  } dps_jtag_t;

  // Pads as seen by the SPI device
  typedef struct packed {
    logic sck;
    logic csb;
    logic sdi;
  } dps_spi_t;

  // IEEE 1149.1 TAP controller states
  typedef enum logic [3:0] {
    TAP_TLR,      TAP_RTI,      TAP_SEL_DR,   TAP_CAP_DR,
    TAP_SHIFT_DR, TAP_EXIT1_DR, TAP_PAUSE_DR, TAP_EXIT2_DR,
    TAP_UPD_DR,   TAP_SEL_IR,   TAP_CAP_IR,   TAP_SHIFT_IR,
    TAP_EXIT1_IR, TAP_PAUSE_IR, TAP_EXIT2_IR, TAP_UPD_IR
  } tap_state_e;

endpackage

//--- logic/pad_sync.sv
//********************************************************************
// Two-flop synchroniser for a whole struct of slow pad levels.
// Instantiate once per bundle; RESET_VAL sets the idle levels
//********************************************************************
module pad_sync #(
  parameter type T         = logic,
  parameter T    RESET_VAL = '0
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  T     d_i,
  output T     q_o
);

  T meta_q;  // May go metastable
  T sync_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      meta_q <= RESET_VAL;
      sync_q <= RESET_VAL;
    end else begin
      meta_q <= d_i;
      sync_q <= meta_q;
    end
  end

  assign q_o = sync_q;

endmodule

//--- logic/debug_strap_mux.sv
//********************************************************************
// Strap latch and shared-pad steering. Picks JTAG or SPI once per
// reset, parks the unused target and returns its serial output
//********************************************************************
module debug_strap_mux import dps_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  dps_pad_t   pad_i,
  input  dps_strap_t strap_i,
  input  logic       tdo_i,
  input  logic       sdo_i,
  output dps_jtag_t  jtag_o,
  output dps_spi_t   spi_o,
  output logic       sdo_tdo_o,
  output logic       jtag_mode_o,
  output logic       bootstrap_o,
  output logic       sys_rst_req_o
);

  logic [2:0] arm_q;      // Reset release pipe
  logic       strap_en;
  logic       jtag_mode_q;
  logic       bootstrap_q;
  logic       sdo_tdo_q;
  logic       rst_req_q;

  // Synchronised straps are valid two edges after release
  assign strap_en = arm_q[1] & ~arm_q[2];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      arm_q       <= '0;
      jtag_mode_q <= 1'b0;
      bootstrap_q <= 1'b0;
    end else begin
      arm_q <= {arm_q[1:0], 1'b1};
      if (strap_en) begin
        jtag_mode_q <= strap_i.jtag_spi_n;
        bootstrap_q <= strap_i.bootstrap;
      end
    end
  end

  always_comb begin
    if (jtag_mode_q) begin
      jtag_o = '{tck: pad_i.sck_tck, tms: pad_i.csb_tms, tdi: pad_i.sdi_tdi,
                 trst_n: pad_i.trst_n};
      spi_o  = '{sck: 1'b0, csb: 1'b1, sdi: 1'b0};  // Deselected
    end else begin
      jtag_o = '{tck: 1'b0, tms: 1'b1, tdi: 1'b0, trst_n: 1'b0};  // TAP held in reset
      spi_o  = '{sck: pad_i.sck_tck, csb: pad_i.csb_tms, sdi: pad_i.sdi_tdi};
    end
  end

  // Serial return and reset request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sdo_tdo_q <= 1'b0;
      rst_req_q <= 1'b0;
    end else begin
      sdo_tdo_q <= jtag_mode_q ? tdo_i : sdo_i;
      rst_req_q <= ~strap_i.srst_n;
    end
  end

  assign sdo_tdo_o     = sdo_tdo_q;
  assign jtag_mode_o   = jtag_mode_q;
  assign bootstrap_o   = bootstrap_q;
  assign sys_rst_req_o = rst_req_q;

  // SPI device must never see a select in JTAG mode
  a_spi_parked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    jtag_mode_q |-> spi_o.csb);

  // Once latched the mode holds until the next reset
  a_mode_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    arm_q[2] |=> $stable(jtag_mode_q));

endmodule

//--- jtag/jtag_tap.sv
//********************************************************************
// 1149.1 TAP with IDCODE and BYPASS, oversampled in the core clock.
// TCK edges are found on a registered copy of the routed pin
//********************************************************************
`include "dps_defs.svh"

module jtag_tap import dps_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  dps_jtag_t jtag_i,
  output logic      tdo_o
);

  tap_state_e           state_q;
  tap_state_e           state_d;
  logic                 tck_q;
  logic                 tck_rise;
  logic                 tck_fall;
  logic [`DPS_IR_W-1:0] ir_q;
  logic [`DPS_IR_W-1:0] ir_shift_q;
  logic [31:0]          idcode_q;
  logic                 bypass_q;
  logic                 sel_idcode;
  logic                 tdo_q;

  assign tck_rise = jtag_i.tck & ~tck_q;
  assign tck_fall = ~jtag_i.tck & tck_q;

  always_comb begin
    case (state_q)
      TAP_TLR:      state_d = jtag_i.tms ? TAP_TLR      : TAP_RTI;
      TAP_RTI:      state_d = jtag_i.tms ? TAP_SEL_DR   : TAP_RTI;
      TAP_SEL_DR:   state_d = jtag_i.tms ? TAP_SEL_IR   : TAP_CAP_DR;
      TAP_CAP_DR:   state_d = jtag_i.tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
      TAP_SHIFT_DR: state_d = jtag_i.tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
      TAP_EXIT1_DR: state_d = jtag_i.tms ? TAP_UPD_DR   : TAP_PAUSE_DR;
      TAP_PAUSE_DR: state_d = jtag_i.tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
      TAP_EXIT2_DR: state_d = jtag_i.tms ? TAP_UPD_DR   : TAP_SHIFT_DR;
      TAP_UPD_DR:   state_d = jtag_i.tms ? TAP_SEL_DR   : TAP_RTI;
      TAP_SEL_IR:   state_d = jtag_i.tms ? TAP_TLR      : TAP_CAP_IR;
      TAP_CAP_IR:   state_d = jtag_i.tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
      TAP_SHIFT_IR: state_d = jtag_i.tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
      TAP_EXIT1_IR: state_d = jtag_i.tms ? TAP_UPD_IR   : TAP_PAUSE_IR;
      TAP_PAUSE_IR: state_d = jtag_i.tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
      TAP_EXIT2_IR: state_d = jtag_i.tms ? TAP_UPD_IR   : TAP_SHIFT_IR;
      TAP_UPD_IR:   state_d = jtag_i.tms ? TAP_SEL_DR   : TAP_RTI;
      default:      state_d = TAP_TLR;
    endcase
  end

  // Instruction decode
  always_comb begin
    case (ir_q)
      `DPS_IR_IDCODE: sel_idcode = 1'b1;
      `DPS_IR_BYPASS: sel_idcode = 1'b0;
      default:        sel_idcode = 1'b0;  // Unknown codes act as BYPASS
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tck_q   <= 1'b0;
      state_q <= TAP_TLR;
      ir_q    <= `DPS_IR_IDCODE;
    end else begin
      tck_q <= jtag_i.tck;
      if (!jtag_i.trst_n) begin
        state_q <= TAP_TLR;
        ir_q    <= `DPS_IR_IDCODE;
      end else begin
        if (tck_rise) begin
          state_q <= state_d;
        end
        if (state_q == TAP_TLR) begin
          ir_q <= `DPS_IR_IDCODE;
        end else if (tck_rise && state_q == TAP_UPD_IR) begin
          ir_q <= ir_shift_q;
        end
      end
    end
  end

  // Shift paths, all LSB first
  always_ff @(posedge clk_i) begin
    if (tck_rise) begin
      case (state_q)
        TAP_CAP_IR:   ir_shift_q <= {{(`DPS_IR_W-1){1'b0}}, 1'b1};
        TAP_SHIFT_IR: ir_shift_q <= {jtag_i.tdi, ir_shift_q[`DPS_IR_W-1:1]};
        TAP_CAP_DR: begin
          if (sel_idcode) idcode_q <= `DPS_IDCODE;
          else            bypass_q <= 1'b0;
        end
        TAP_SHIFT_DR: begin
          if (sel_idcode) idcode_q <= {jtag_i.tdi, idcode_q[31:1]};
          else            bypass_q <= jtag_i.tdi;
        end
        default: ;
      endcase
    end
  end

  // TDO changes on the falling edge
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tdo_q <= 1'b0;
    end else if (tck_fall) begin
      case (state_q)
        TAP_SHIFT_IR: tdo_q <= ir_shift_q[0];
        TAP_SHIFT_DR: tdo_q <= sel_idcode ? idcode_q[0] : bypass_q;
        default:      tdo_q <= 1'b0;
      endcase
    end
  end

  assign tdo_o = tdo_q;

  a_trst_holds_tlr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !jtag_i.trst_n |=> state_q == TAP_TLR);

endmodule

//--- spi/spi_echo_device.sv
//********************************************************************
// SPI mode-0 device that reports every received byte and sends the
// byte before it back on SDO, MSB first
//********************************************************************
`include "dps_defs.svh"

module spi_echo_device import dps_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  dps_spi_t              spi_i,
  output logic                  sdo_o,
  output logic                  rx_valid_o,
  output logic [`DPS_SPI_W-1:0] rx_data_o
);

  localparam int CNT_W = $clog2(`DPS_SPI_W);

  logic                  sck_q;
  logic                  csb_q;
  logic                  sck_rise;
  logic                  sck_fall;
  logic                  csb_fall;
  logic                  last_bit;
  logic [CNT_W-1:0]      bit_cnt_q;
  logic [`DPS_SPI_W-1:0] rx_shift_q;
  logic [`DPS_SPI_W-1:0] echo_q;      // Last full byte
  logic [`DPS_SPI_W-1:0] tx_shift_q;
  logic                  rx_valid_q;

  assign sck_rise = spi_i.sck & ~sck_q & ~spi_i.csb;
  assign sck_fall = ~spi_i.sck & sck_q & ~spi_i.csb;
  assign csb_fall = csb_q & ~spi_i.csb;
  assign last_bit = (bit_cnt_q == CNT_W'(`DPS_SPI_W - 1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sck_q      <= 1'b0;
      csb_q      <= 1'b1;
      bit_cnt_q  <= '0;
      rx_valid_q <= 1'b0;
      echo_q     <= '0;
      tx_shift_q <= '0;
    end else begin
      sck_q      <= spi_i.sck;
      csb_q      <= spi_i.csb;
      rx_valid_q <= sck_rise & last_bit;

      if (spi_i.csb) begin
        bit_cnt_q <= '0;
      end else if (sck_rise) begin
        bit_cnt_q <= last_bit ? '0 : bit_cnt_q + 1'b1;
      end

      if (sck_rise && last_bit) begin
        echo_q <= {rx_shift_q[`DPS_SPI_W-2:0], spi_i.sdi};
      end

      // Reload at frame start and at each byte boundary
      if (csb_fall) begin
        tx_shift_q <= echo_q;
      end else if (sck_fall) begin
        if (bit_cnt_q == '0) tx_shift_q <= echo_q;
        else                 tx_shift_q <= {tx_shift_q[`DPS_SPI_W-2:0], 1'b0};
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sck_rise) begin
      rx_shift_q <= {rx_shift_q[`DPS_SPI_W-2:0], spi_i.sdi};  // MSB first
    end
  end

  assign sdo_o      = tx_shift_q[`DPS_SPI_W-1];
  assign rx_valid_o = rx_valid_q;
  assign rx_data_o  = echo_q;

  a_no_rx_deselected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_valid_o |-> !spi_i.csb);

endmodule

//--- logic/dps_top.sv
//********************************************************************
// Debug-port top level. Synchronises the DPS pads and straps, then
// hands the shared pads to the JTAG TAP or the SPI echo device
//********************************************************************
`include "dps_defs.svh"

module dps_top import dps_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  dps_pad_t              dps_pad_i,
  input  dps_strap_t            dps_strap_i,
  output logic                  dps_sdo_tdo_o,
  output logic                  jtag_mode_o,
  output logic                  bootstrap_o,
  output logic                  sys_rst_req_o,
  output logic                  spi_rx_valid_o,
  output logic [`DPS_SPI_W-1:0] spi_rx_data_o
);

  // Idle pad levels, CSB deselected and SRST_N released
  localparam dps_pad_t PAD_RST_VAL =
    '{sck_tck: 1'b0, sdi_tdi: 1'b0, csb_tms: 1'b1, trst_n: 1'b0};
  localparam dps_strap_t STRAP_RST_VAL =
    '{jtag_spi_n: 1'b0, bootstrap: 1'b0, srst_n: 1'b1};

  dps_pad_t   pad_sync;
  dps_strap_t strap_sync;
  dps_jtag_t  jtag;
  dps_spi_t   spi;
  logic       tdo;
  logic       sdo;

  pad_sync #(.T(dps_pad_t), .RESET_VAL(PAD_RST_VAL)) u_pad_sync (
    .clk_i, .rst_n_i, .d_i(dps_pad_i), .q_o(pad_sync)
  );

  pad_sync #(.T(dps_strap_t), .RESET_VAL(STRAP_RST_VAL)) u_strap_sync (
    .clk_i, .rst_n_i, .d_i(dps_strap_i), .q_o(strap_sync)
  );

  debug_strap_mux u_debug_strap_mux (
    .clk_i,
    .rst_n_i,
    .pad_i         (pad_sync),
    .strap_i       (strap_sync),
    .tdo_i         (tdo),
    .sdo_i         (sdo),
    .jtag_o        (jtag),
    .spi_o         (spi),
    .sdo_tdo_o     (dps_sdo_tdo_o),
    .jtag_mode_o,
    .bootstrap_o,
    .sys_rst_req_o
  );

  jtag_tap u_jtag_tap (.clk_i, .rst_n_i, .jtag_i(jtag), .tdo_o(tdo));

  spi_echo_device u_spi_echo_device (
    .clk_i,
    .rst_n_i,
    .spi_i      (spi),
    .sdo_o      (sdo),
    .rx_valid_o (spi_rx_valid_o),
    .rx_data_o  (spi_rx_data_o)
  );

endmodule

//--- verif/tb_dps_top.sv
//********************************************************************
// Testbench for the debug-port top level. Covers strap latching, SPI
// echo, IDCODE and BYPASS reads and the system reset request
//********************************************************************
`include "dps_defs.svh"

module tb_dps_top import dps_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HOLD = 10;  // clk_i cycles per TCK/SCK level
  // About 250 serial clocks of two levels each, plus resets and idle gaps
  localparam int TEST_CYCLES = 260 * 2 * HOLD + 200;
  localparam int WATCHDOG_NS = 2 * TEST_CYCLES * 4;
  localparam dps_pad_t PAD_IDLE =
    '{sck_tck: 1'b0, sdi_tdi: 1'b0, csb_tms: 1'b1, trst_n: 1'b1};

  logic                  clk_i = 1'b0;
  logic                  rst_n_i;
  dps_pad_t              pad_drv;
  dps_strap_t            strap_drv;
  logic                  dps_sdo_tdo_o;
  logic                  jtag_mode_o;
  logic                  bootstrap_o;
  logic                  sys_rst_req_o;
  logic                  spi_rx_valid_o;
  logic [`DPS_SPI_W-1:0] spi_rx_data_o;
  logic [`DPS_SPI_W-1:0] rx_data_q;       // Byte of the last rx pulse
  logic [`DPS_SPI_W-1:0] spi_bytes [6];
  int                    rx_count  = 0;
  int                    err_cnt   = 0;
  int                    check_cnt = 0;

  always #2 clk_i = ~clk_i;

  dps_top dut0 (
    .clk_i, .rst_n_i, .dps_pad_i(pad_drv), .dps_strap_i(strap_drv),
    .dps_sdo_tdo_o, .jtag_mode_o, .bootstrap_o, .sys_rst_req_o,
    .spi_rx_valid_o, .spi_rx_data_o
  );

  always @(posedge clk_i) begin
    if (rst_n_i && spi_rx_valid_o) begin
      rx_count  <= rx_count + 1;
      rx_data_q <= spi_rx_data_o;
    end
  end

  a_no_rx_in_jtag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    jtag_mode_o |-> !spi_rx_valid_o) else begin
    err_cnt++;
    $display("[ERROR] %0d ns: spi_rx_valid_o expected 0, got 1 (JTAG mode)", $time);
  end

  a_rx_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    spi_rx_valid_o |=> !spi_rx_valid_o) else begin
    err_cnt++;
    $display("[ERROR] %0d ns: spi_rx_valid_o expected 0, got 1 (long pulse)", $time);
  end

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;  // Drive and sample off the edge
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("[ERROR] %0d ns: %s expected %0h, got %0h", $time, name, exp, got);
    end
  endtask

  task automatic apply_reset(input logic jtag_sel, input logic boot);
    rst_n_i   = 1'b0;
    pad_drv   = PAD_IDLE;
    strap_drv = '{jtag_spi_n: jtag_sel, bootstrap: boot, srst_n: 1'b1};
    wait_cycles(2);
    rst_n_i = 1'b1;
    wait_cycles(1);
    check_value("spi_rx_valid_o", 0, spi_rx_valid_o);
    check_value("sys_rst_req_o", 0, sys_rst_req_o);
    check_value("dps_sdo_tdo_o", 0, dps_sdo_tdo_o);
    check_value("jtag_mode_o", 0, jtag_mode_o);
    check_value("bootstrap_o", 0, bootstrap_o);
    wait_cycles(4);  // Straps latched by now
    check_value("jtag_mode_o", jtag_sel, jtag_mode_o);
    check_value("bootstrap_o", boot, bootstrap_o);
  endtask

  // Flip the strap pads and expect the latched copies to hold
  task automatic check_strap_hold(input logic jtag_sel, input logic boot);
    strap_drv.jtag_spi_n = ~jtag_sel;
    strap_drv.bootstrap  = ~boot;
    wait_cycles(HOLD);
    check_value("jtag_mode_o", jtag_sel, jtag_mode_o);
    check_value("bootstrap_o", boot, bootstrap_o);
    strap_drv.jtag_spi_n = jtag_sel;
    strap_drv.bootstrap  = boot;
    wait_cycles(4);
  endtask

  task automatic spi_send_byte(input logic [7:0] data, input logic echo_on,
                               input logic [7:0] exp_sdo);
    logic [7:0] sdo_bits;
    int         base;
    int         n;
    base = rx_count;
    for (int i = 7; i >= 0; i--) begin
      pad_drv.sdi_tdi = data[i];
      wait_cycles(HOLD);
      sdo_bits[i] = dps_sdo_tdo_o;  // Just before the rise
      pad_drv.sck_tck = 1'b1;
      n = 0;
      while (echo_on && i == 0 && rx_count == base && n < HOLD) begin
        wait_cycles(1);
        n++;
      end
      wait_cycles(HOLD - n);
      pad_drv.sck_tck = 1'b0;
    end
    if (echo_on) begin
      check_cnt++;
      assert (rx_count != base) else begin
        err_cnt++;
        $display("No spi_rx_valid_o pulse came at %0d ns for byte %0h", $time, data);
      end
      check_value("spi_rx_data_o", data, rx_data_q);
      check_value("dps_sdo_tdo_o echo byte", exp_sdo, sdo_bits);
    end
  endtask

  task automatic spi_frame(input logic echo_on);
    logic [7:0] prev;
    int         start;
    start = rx_count;
    prev  = 8'h00;  // Echo word after reset
    pad_drv.csb_tms = 1'b0;
    for (int b = 0; b < 6; b++) begin
      spi_send_byte(spi_bytes[b], echo_on, prev);
      prev = spi_bytes[b];
    end
    pad_drv.csb_tms = 1'b1;
    wait_cycles(HOLD);
    check_value("spi_rx_valid_o pulse count", echo_on ? start + 6 : start, rx_count);
  endtask

  task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
    pad_drv.csb_tms = tms;
    pad_drv.sdi_tdi = tdi;
    wait_cycles(HOLD);
    tdo = dps_sdo_tdo_o;
    pad_drv.sck_tck = 1'b1;
    wait_cycles(HOLD);
    pad_drv.sck_tck = 1'b0;
  endtask

  // TMS sequence, LSB first, TDI low
  task automatic walk_tms(input logic [15:0] seq, input int n);
    logic unused_tdo;
    for (int i = 0; i < n; i++) tck_cycle(seq[i], 1'b0, unused_tdo);
  endtask

  // Shift n bits LSB first, TMS high on the last to leave the shift state
  task automatic shift_bits(input int n, input logic [31:0] tdi, output logic [31:0] tdo);
    tdo = '0;
    for (int i = 0; i < n; i++) tck_cycle(i == n - 1, tdi[i], tdo[i]);
  endtask

  task automatic wait_rst_req(input logic exp);
    int n;
    n = 0;
    while (sys_rst_req_o !== exp && n < 5) begin
      wait_cycles(1);
      n++;
    end
    check_value("sys_rst_req_o", exp, sys_rst_req_o);
  endtask

  initial begin
    logic [31:0] bits;
    logic [31:0] tdi_bits;
    rst_n_i   = 1'b0;
    pad_drv   = PAD_IDLE;
    strap_drv = '{jtag_spi_n: 1'b0, bootstrap: 1'b0, srst_n: 1'b1};
    void'($urandom(32'h7b7934e6));
    foreach (spi_bytes[i]) spi_bytes[i] = 8'($urandom);

    apply_reset(1'b0, 1'b1);  // SPI mode
    check_strap_hold(1'b0, 1'b1);
    spi_frame(1'b1);

    apply_reset(1'b1, 1'b0);  // JTAG mode, same SPI traffic
    check_strap_hold(1'b1, 1'b0);
    spi_frame(1'b0);

    walk_tms(16'h005F, 9);    // Test-Logic-Reset, then Shift-DR
    shift_bits(32, '0, bits);
    walk_tms(16'h0001, 2);
    check_value("dps_sdo_tdo_o IDCODE", `DPS_IDCODE, bits);

    walk_tms(16'h005F, 9);    // Abort a read halfway with trst_n
    walk_tms(16'h0000, 16);   // Half the IDCODE, still in Shift-DR
    pad_drv.trst_n = 1'b0;
    wait_cycles(HOLD);
    pad_drv.trst_n = 1'b1;
    walk_tms(16'h0002, 4);    // Straight from Test-Logic-Reset to Shift-DR
    shift_bits(32, '0, bits);
    walk_tms(16'h0001, 2);
    check_value("dps_sdo_tdo_o IDCODE after trst_n", `DPS_IDCODE, bits);

    walk_tms(16'h00DF, 10);   // Test-Logic-Reset, then Shift-IR
    shift_bits(`DPS_IR_W, 32'(`DPS_IR_BYPASS), bits);
    walk_tms(16'h0005, 5);    // Update-IR, then Shift-DR
    tdi_bits = $urandom;
    shift_bits(16, tdi_bits, bits);
    walk_tms(16'h0001, 2);
    check_value("dps_sdo_tdo_o BYPASS", {tdi_bits[14:0], 1'b0}, bits[15:0]);

    strap_drv.srst_n = 1'b0;
    wait_rst_req(1'b1);
    strap_drv.srst_n = 1'b1;
    wait_rst_req(1'b0);

    $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #WATCHDOG_NS;
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+common
common/dps_pkg.sv
logic/pad_sync.sv
logic/debug_strap_mux.sv
jtag/jtag_tap.sv
spi/spi_echo_device.sv
logic/dps_top.sv
verif/tb_dps_top.sv

//--- Bender.yml
package:
  name: dps_debug_port

export_include_dirs:
  - common

sources:
  - common/dps_pkg.sv
  - logic/pad_sync.sv
  - logic/debug_strap_mux.sv
  - jtag/jtag_tap.sv
  - spi/spi_echo_device.sv
  - logic/dps_top.sv
  - target: test
    files:
      - verif/tb_dps_top.sv
